/* rtl/box_pkg.sv */
`default_nettype none

package box_pkg;

  // image geometry.
  localparam int IMG_COLS = 16;
  localparam int IMG_ROWS = 12;
  localparam int WIN      = 5;

  localparam int PIX_W     = 8;
  localparam int COL_SUM_W = 11;  // 5 x 255 = 1275.
  localparam int WIN_SUM_W = 13;  // 25 x 255 = 6375.

  // pixel strobe to result strobe.
  localparam int PIPE_LAT   = 4;
  localparam int CENTER_OFS = 2;

  typedef logic [PIX_W-1:0]     pix_t;
  typedef logic [COL_SUM_W-1:0] col_sum_t;
  typedef logic [WIN_SUM_W-1:0] win_sum_t;

  typedef logic [$clog2(IMG_COLS)-1:0] col_idx_t;
  typedef logic [$clog2(IMG_ROWS)-1:0] row_idx_t;

endpackage

`default_nettype wire

/* rtl/delay_line.sv */
`default_nettype none

module delay_line #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = 2
) (
  input  wire   clk,
  input  wire   rst_n,
  input  wire   i_en,
  input  wire T i_d,
  output T      o_q
);

  T sr [DEPTH];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < DEPTH; k++) begin
        sr[k] <= '0;
      end
    end else if (i_en) begin
      sr[0] <= i_d;
      for (int k = 1; k < DEPTH; k++) begin
        sr[k] <= sr[k-1];
      end
    end
  end

  // oldest entry, written DEPTH steps back.
  assign o_q = sr[DEPTH-1];

endmodule

`default_nettype wire

/* rtl/line_buffer.sv */
`default_nettype none

module line_buffer (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    i_wr,
  input  wire box_pkg::col_idx_t i_col,
  input  wire box_pkg::pix_t     i_pix,
  output logic                   o_col_valid,
  output box_pkg::pix_t          o_tap0,
  output box_pkg::pix_t          o_tap1,
  output box_pkg::pix_t          o_tap2,
  output box_pkg::pix_t          o_tap3,
  output box_pkg::pix_t          o_tap4
);
  import box_pkg::*;

  // mem[0] holds the previous row, mem[WIN-2] the oldest.
  pix_t mem [WIN-1][IMG_COLS];

  always_ff @(posedge clk) begin
    if (i_wr) begin
      mem[0][i_col] <= i_pix;
      for (int k = 1; k < WIN - 1; k++) begin
        mem[k][i_col] <= mem[k-1][i_col];
      end
      o_tap0 <= mem[3][i_col];  // row r-4.
      o_tap1 <= mem[2][i_col];
      o_tap2 <= mem[1][i_col];
      o_tap3 <= mem[0][i_col];
      o_tap4 <= i_pix;          // current row.
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_col_valid <= 1'b0;
    end else begin
      o_col_valid <= i_wr;
    end
  end

endmodule

`default_nettype wire

/* rtl/column_adder.sv */
`default_nettype none

module column_adder (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                i_valid,
  input  wire box_pkg::pix_t i_tap0,
  input  wire box_pkg::pix_t i_tap1,
  input  wire box_pkg::pix_t i_tap2,
  input  wire box_pkg::pix_t i_tap3,
  input  wire box_pkg::pix_t i_tap4,
  output logic               o_sum_valid,
  output box_pkg::col_sum_t  o_col_sum,
  output box_pkg::pix_t      o_mid
);
  import box_pkg::*;

  logic           s1_valid;
  logic [PIX_W:0] s1_p01;
  logic [PIX_W:0] s1_p23;
  pix_t           s1_t4;
  pix_t           s1_t2;

  // stage one adds the tap pairs.
  always_ff @(posedge clk) begin
    if (i_valid) begin
      s1_p01 <= {1'b0, i_tap0} + {1'b0, i_tap1};
      s1_p23 <= {1'b0, i_tap2} + {1'b0, i_tap3};
      s1_t4  <= i_tap4;
      s1_t2  <= i_tap2;
    end
  end

  // stage two adds up the column.
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      o_col_sum <= col_sum_t'(s1_p01) + col_sum_t'(s1_p23) + col_sum_t'(s1_t4);
      o_mid     <= s1_t2;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid    <= 1'b0;
      o_sum_valid <= 1'b0;
    end else begin
      s1_valid    <= i_valid;
      o_sum_valid <= s1_valid;
    end
  end

endmodule

`default_nettype wire

/* rtl/window_accumulator.sv */
`default_nettype none

module window_accumulator (
  input  wire                    clk,
  input  wire                    i_en,
  input  wire                    i_ld,
  input  wire                    i_sub,
  input  wire box_pkg::col_sum_t i_new,
  input  wire box_pkg::col_sum_t i_old,
  output box_pkg::win_sum_t      o_sum
);
  import box_pkg::*;

  win_sum_t add_term;
  win_sum_t sub_term;

  assign add_term = win_sum_t'(i_new);
  // column leaving the window, once five are in.
  assign sub_term = i_sub ? win_sum_t'(i_old) : '0;

  always_ff @(posedge clk) begin
    if (i_ld) begin
      o_sum <= add_term;  // first column of a row.
    end else if (i_en) begin
      o_sum <= o_sum + add_term - sub_term;
    end
  end

endmodule

`default_nettype wire

/* rtl/box_ctrl.sv */
`default_nettype none

module box_ctrl (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                i_pix_valid,
  input  wire                i_frame_start,
  output logic               o_lb_wr,
  output box_pkg::col_idx_t  o_col,
  output logic               o_acc_en,
  output logic               o_acc_ld,
  output logic               o_acc_sub,
  output logic               o_sum_valid,
  output logic               o_frame_done
);
  import box_pkg::*;

  // flag stages ahead of the output register.
  localparam int STAGES = PIPE_LAT - 1;

  col_idx_t          col_q;
  row_idx_t          row_q;
  logic              pix_ok;
  logic              busy;
  logic              flush;
  logic              col_last;
  logic              row_last;
  logic [STAGES-1:0] vld_q;
  logic [STAGES-1:0] win_q;
  logic [STAGES-1:0] first_q;
  logic [STAGES-1:0] sub_q;
  logic [STAGES-1:0] last_q;

  assign busy     = (col_q != '0) || (row_q != '0);
  assign flush    = i_frame_start && busy;  // abandons the frame in flight.
  assign pix_ok   = i_pix_valid && !i_frame_start;
  assign col_last = (col_q == col_idx_t'(IMG_COLS - 1));
  assign row_last = (row_q == row_idx_t'(IMG_ROWS - 1));

  assign o_lb_wr = pix_ok;
  assign o_col   = col_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_q <= '0;
      row_q <= '0;
    end else if (i_frame_start) begin
      col_q <= '0;
      row_q <= '0;
    end else if (pix_ok) begin
      if (col_last) begin
        col_q <= '0;
        row_q <= row_last ? '0 : row_q + 1'b1;  // wraps at frame end.
      end else begin
        col_q <= col_q + 1'b1;
      end
    end
  end

  // per-pixel conditions, matched to the datapath depth.
  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      vld_q   <= '0;
      win_q   <= '0;
      first_q <= '0;
      sub_q   <= '0;
      last_q  <= '0;
    end else begin
      vld_q   <= {vld_q[STAGES-2:0], pix_ok};
      win_q   <= {win_q[STAGES-2:0], (row_q >= WIN - 1) && (col_q >= WIN - 1)};
      first_q <= {first_q[STAGES-2:0], col_q == '0};
      sub_q   <= {sub_q[STAGES-2:0], col_q >= WIN};
      last_q  <= {last_q[STAGES-2:0], row_last && col_last};
    end
  end

  // lines up with column_adder's o_sum_valid.
  assign o_acc_en  = vld_q[STAGES-1];
  assign o_acc_ld  = vld_q[STAGES-1] && first_q[STAGES-1];
  assign o_acc_sub = vld_q[STAGES-1] && sub_q[STAGES-1];

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      o_sum_valid  <= 1'b0;
      o_frame_done <= 1'b0;
    end else begin
      o_sum_valid  <= vld_q[STAGES-1] && win_q[STAGES-1];
      o_frame_done <= vld_q[STAGES-1] && last_q[STAGES-1];
    end
  end

endmodule

`default_nettype wire

/* rtl/box_sum_top.sv */
`default_nettype none

module box_sum_top (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                i_pix_valid,
  input  wire box_pkg::pix_t i_pix,
  input  wire                i_frame_start,
  output logic               o_sum_valid,
  output box_pkg::win_sum_t  o_sum,
  output box_pkg::pix_t      o_center,
  output logic               o_frame_done
);
  import box_pkg::*;

  logic     lb_wr;
  col_idx_t lb_col;
  logic     acc_en;
  logic     acc_ld;
  logic     acc_sub;
  logic     tap_valid;
  pix_t     tap0;
  pix_t     tap1;
  pix_t     tap2;
  pix_t     tap3;
  pix_t     tap4;
  logic     col_valid;
  col_sum_t col_sum;
  col_sum_t old_sum;
  pix_t     mid_pix;

  box_ctrl u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_pix_valid   (i_pix_valid),
    .i_frame_start (i_frame_start),
    .o_lb_wr       (lb_wr),
    .o_col         (lb_col),
    .o_acc_en      (acc_en),
    .o_acc_ld      (acc_ld),
    .o_acc_sub     (acc_sub),
    .o_sum_valid   (o_sum_valid),
    .o_frame_done  (o_frame_done)
  );

  line_buffer u_lb (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_wr        (lb_wr),
    .i_col       (lb_col),
    .i_pix       (i_pix),
    .o_col_valid (tap_valid),
    .o_tap0      (tap0),
    .o_tap1      (tap1),
    .o_tap2      (tap2),
    .o_tap3      (tap3),
    .o_tap4      (tap4)
  );

  column_adder u_col (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_valid     (tap_valid),
    .i_tap0      (tap0),
    .i_tap1      (tap1),
    .i_tap2      (tap2),
    .i_tap3      (tap3),
    .i_tap4      (tap4),
    .o_sum_valid (col_valid),
    .o_col_sum   (col_sum),
    .o_mid       (mid_pix)
  );

  // column sum from five columns back.
  delay_line #(.T(col_sum_t), .DEPTH(WIN)) u_sub_dly (
    .clk   (clk),
    .rst_n (rst_n),
    .i_en  (col_valid),
    .i_d   (col_sum),
    .o_q   (old_sum)
  );

  // one extra step holds the centre with o_sum.
  delay_line #(.T(pix_t), .DEPTH(CENTER_OFS + 1)) u_ctr_dly (
    .clk   (clk),
    .rst_n (rst_n),
    .i_en  (col_valid),
    .i_d   (mid_pix),
    .o_q   (o_center)
  );

  window_accumulator u_acc (
    .clk   (clk),
    .i_en  (acc_en),
    .i_ld  (acc_ld),
    .i_sub (acc_sub),
    .i_new (col_sum),
    .i_old (old_sum),
    .o_sum (o_sum)
  );

endmodule

`default_nettype wire

/* bench/tb_box_sum.sv */
`default_nettype none

module tb_box_sum;
  timeunit 1ns;
  timeprecision 100ps;
  import box_pkg::*;

  localparam int N_PIX       = IMG_ROWS * IMG_COLS;
  localparam int MAX_GAP     = 3;
  localparam int N_FRAMES    = 6;
  localparam int WATCHDOG_NS = N_FRAMES * N_PIX * (MAX_GAP + 1) * 4 + 2000;
  localparam int FILL_RANDOM = 0;
  localparam int FILL_MAX    = 1;
  localparam int FILL_ZERO   = 2;

  logic     clk;
  logic     rst_n;
  logic     i_pix_valid;
  pix_t     i_pix;
  logic     i_frame_start;
  logic     o_sum_valid;
  win_sum_t o_sum;
  pix_t     o_center;
  logic     o_frame_done;

  pix_t        img [IMG_ROWS][IMG_COLS];  // frame being driven.
  logic [31:0] rng;
  int          cyc;
  int          n_got;
  int          err_val;
  int          err_time;
  int          err_extra;
  int          err_miss;
  win_sum_t    exp_sum_q [$];
  pix_t        exp_ctr_q [$];
  int          exp_due_q [$];
  int          done_due_q [$];

  box_sum_top DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_pix_valid   (i_pix_valid),
    .i_pix         (i_pix),
    .i_frame_start (i_frame_start),
    .o_sum_valid   (o_sum_valid),
    .o_sum         (o_sum),
    .o_center      (o_center),
    .o_frame_done  (o_frame_done)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // posedges seen so far.
  initial cyc = 0;
  always @(posedge clk) cyc <= cyc + 1;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // sum over rows r-4..r and columns c-4..c.
  function automatic win_sum_t ref_window_sum(input int r, input int c);
    int acc;
    acc = 0;
    for (int dr = 0; dr < WIN; dr++) begin
      for (int dc = 0; dc < WIN; dc++) begin
        acc = acc + int'(img[r-dr][c-dc]);
      end
    end
    return win_sum_t'(acc);
  endfunction

  task automatic check_sum(input int idx, input win_sum_t got, input win_sum_t exp);
    if (got !== exp) begin
      $display("ERR %0t: result %0d window sum %0d, expected %0d", $time, idx, got, exp);
      err_val++;
    end
  endtask

  task automatic check_center(input int idx, input pix_t got, input pix_t exp);
    if (got !== exp) begin
      $display("ERR %0t: result %0d centre %0d, expected %0d", $time, idx, got, exp);
      err_val++;
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((exp_sum_q.size() != 0 || done_due_q.size() != 0) && n < 4 * PIPE_LAT) begin
      @(negedge clk);
      n++;
    end
  endtask

  // frame start pulse, then npix pixels in raster order.
  task automatic run_frame(input int mode, input int max_gap, input int npix);
    int   r;
    int   c;
    int   gap;
    pix_t p;
    wait_drain();
    @(negedge clk);
    i_frame_start = 1'b1;
    @(negedge clk);
    i_frame_start = 1'b0;
    for (int k = 0; k < npix; k++) begin
      r = k / IMG_COLS;
      c = k % IMG_COLS;
      rng = xorshift32(rng);
      gap = (max_gap > 0) ? int'(rng[15:8]) % (max_gap + 1) : 0;
      case (mode)
        FILL_MAX:  p = 8'hff;
        FILL_ZERO: p = '0;
        default:   p = rng[7:0];
      endcase
      repeat (gap) begin
        @(negedge clk);
        i_pix_valid = 1'b0;
      end
      @(negedge clk);
      i_pix_valid = 1'b1;
      i_pix       = p;
      img[r][c]   = p;
      // strobe visible from edge t+3, with t = cyc + 1.
      if (r >= WIN - 1 && c >= WIN - 1) begin
        exp_sum_q.push_back(ref_window_sum(r, c));
        exp_ctr_q.push_back(img[r-CENTER_OFS][c-CENTER_OFS]);
        exp_due_q.push_back(cyc + PIPE_LAT);
      end
      if (k == N_PIX - 1) begin
        done_due_q.push_back(cyc + PIPE_LAT);
      end
    end
    @(negedge clk);
    i_pix_valid = 1'b0;
  endtask

  initial begin : compare
    win_sum_t es;
    pix_t     ec;
    int       due;
    n_got     = 0;
    err_val   = 0;
    err_time  = 0;
    err_extra = 0;
    forever begin
      @(negedge clk);
      if (rst_n !== 1'b1) begin
        if (cyc > 0 && (o_sum_valid === 1'b1 || o_frame_done === 1'b1)) begin
          $display("%0t: an output strobe went high while reset was held", $time);
          err_extra++;
        end
      end else begin
        if (o_sum_valid === 1'b1) begin
          if (exp_sum_q.size() == 0) begin
            $display("%0t: a result appeared that no pixel should have produced", $time);
            err_extra++;
          end else begin
            es  = exp_sum_q.pop_front();
            ec  = exp_ctr_q.pop_front();
            due = exp_due_q.pop_front();
            n_got++;
            check_sum(n_got, o_sum, es);
            check_center(n_got, o_center, ec);
            if (cyc != due) begin
              $display("%0t: result %0d came at cycle %0d instead of cycle %0d",
                       $time, n_got, cyc, due);
              err_time++;
            end
          end
        end
        if (o_frame_done === 1'b1) begin
          if (done_due_q.size() == 0) begin
            $display("%0t: frame done pulsed with no completed frame", $time);
            err_extra++;
          end else begin
            due = done_due_q.pop_front();
            if (cyc != due) begin
              $display("%0t: frame done came at cycle %0d instead of cycle %0d",
                       $time, cyc, due);
              err_time++;
            end
          end
        end
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin : stimulus
    i_pix_valid   = 1'b0;
    i_pix         = '0;
    i_frame_start = 1'b0;
    rst_n         = 1'b0;
    err_miss      = 0;
    rng           = 32'd46641;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    run_frame(FILL_RANDOM, 0, N_PIX);
    run_frame(FILL_RANDOM, MAX_GAP, N_PIX);
    run_frame(FILL_MAX, 0, N_PIX);
    run_frame(FILL_ZERO, 0, N_PIX);
    run_frame(FILL_RANDOM, 0, 6 * IMG_COLS + 7);  // abandoned in row 6.
    run_frame(FILL_RANDOM, MAX_GAP, N_PIX);
    wait_drain();
    repeat (2 * PIPE_LAT) @(negedge clk);  // room for late extras.
    err_miss = exp_sum_q.size() + done_due_q.size();
    if (err_miss != 0) begin
      $display("%0d expected results or frame ends never appeared", err_miss);
    end
    $display("errors: value %0d, timing %0d, missing %0d, extra %0d (results seen %0d)",
             err_val, err_time, err_miss, err_extra, n_got);
    if (err_val + err_time + err_miss + err_extra == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
rtl/box_pkg.sv
rtl/delay_line.sv
rtl/line_buffer.sv
rtl/column_adder.sv
rtl/window_accumulator.sv
rtl/box_ctrl.sv
rtl/box_sum_top.sv
bench/tb_box_sum.sv

/* run.sh */
#!/bin/sh
# compile and run the box-sum testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_box_sum -o sim_tb_box_sum
out=$(./obj_dir/sim_tb_box_sum)
echo "$out"

if echo "$out" | grep -q "TESTBENCH PASSED"; then
  exit 0
else
  exit 1
fi
